/* rvc_decoder.f */
+incdir+src
+incdir+sim
src/rvc_isa_pkg.sv
src/rvc_ctrl_pkg.sv
src/rvc_pipe_reg.sv
src/rvc_field_decode.sv
src/rvc_imm_gen.sv
src/rvc_decoder_top.sv
sim/rvc_decoder_tb.sv

/* Makefile */
TOP := rvc_decoder_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rvc_decoder.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rvc_decoder.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/rvc_ref_model.svh */
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// expected decode of one parcel, taken from the RV32C expansion table
function automatic dec_out_t ref_decode(input logic [15:0] p);
    dec_out_t    r;
    logic [11:0] v;   // scattered immediate bits
    logic [4:0]  rd_f;
    logic [4:0]  rs2_f;
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;

    r = '0;
    v = '0;
    rd_f  = p[11:7];
    rs2_f = p[6:2];
    rs1_p = 5'd8 + p[9:7];   // primed registers live in x8..x15
    rs2_p = 5'd8 + p[4:2];
    r.alu_op = alu_add;
    r.op_class = cls_none;
    r.is_compressed = (p[1:0] != 2'b11);

    case ({p[1:0], p[15:13]})
        5'b00_000: begin   // c.addi4spn
            r.rd = rs2_p;
            r.rs1 = 5'd2;
            r.op_class = cls_alu_imm;
            v[9:6] = p[10:7];
            v[5:4] = p[12:11];
            v[3] = p[5];
            v[2] = p[6];
            r.imm = {20'b0, v};
        end
        5'b00_010, 5'b00_110: begin   // c.lw / c.sw
            r.rs1 = rs1_p;
            if (p[15]) begin
                r.rs2 = rs2_p;
                r.op_class = cls_store;
            end else begin
                r.rd = rs2_p;
                r.op_class = cls_load;
            end
            v[6] = p[5];
            v[5:3] = p[12:10];
            v[2] = p[6];
            r.imm = {20'b0, v};
        end
        5'b01_000, 5'b01_010: begin   // c.addi / c.li
            r.rd = rd_f;
            r.rs1 = p[14] ? 5'd0 : rd_f;
            r.op_class = cls_alu_imm;
            r.is_nop = !p[14] && (rd_f == 5'd0);
            r.imm = {{26{p[12]}}, p[12], p[6:2]};
        end
        5'b01_001, 5'b01_101: begin   // c.jal links to x1, c.j to x0
            r.rd = p[15] ? 5'd0 : 5'd1;
            r.op_class = cls_jump;
            v[11] = p[12];
            v[10] = p[8];
            v[9:8] = p[10:9];
            v[7] = p[6];
            v[6] = p[7];
            v[5] = p[2];
            v[4] = p[11];
            v[3:1] = p[5:3];
            r.imm = {{20{v[11]}}, v};
        end
        5'b01_011: begin
            if (rd_f == 5'd2) begin   // c.addi16sp
                r.rd = 5'd2;
                r.rs1 = 5'd2;
                r.op_class = cls_alu_imm;
                v[9] = p[12];
                v[8:7] = p[4:3];
                v[6] = p[5];
                v[5] = p[2];
                v[4] = p[6];
                r.imm = {{22{v[9]}}, v[9:0]};
            end else begin   // c.lui
                r.rd = rd_f;
                r.op_class = cls_lui;
                r.imm = {{14{p[12]}}, p[12], p[6:2], 12'b0};
            end
        end
        5'b01_100: begin
            r.rd = rs1_p;
            r.rs1 = rs1_p;
            r.op_class = cls_alu_imm;
            case (p[11:10])
                2'd0: r.alu_op = alu_srl;
                2'd1: r.alu_op = alu_sra;
                2'd2: r.alu_op = alu_and;
                default: r.op_class = cls_alu_reg;
            endcase
            if (p[11:10] == 2'd2) begin
                r.imm = {{26{p[12]}}, p[12], p[6:2]};
            end else if (p[11:10] != 2'd3) begin
                r.imm = {26'b0, p[12], p[6:2]};
            end else if (p[12]) begin   // subw / addw space, not in rv32
                r.rd = 5'd0;
                r.rs1 = 5'd0;
                r.op_class = cls_none;
            end else begin
                r.rs2 = rs2_p;
                case (p[6:5])
                    2'd0: r.alu_op = alu_sub;
                    2'd1: r.alu_op = alu_xor;
                    2'd2: r.alu_op = alu_or;
                    default: r.alu_op = alu_and;
                endcase
            end
        end
        5'b01_110, 5'b01_111: begin   // c.beqz / c.bnez
            r.rs1 = rs1_p;
            r.op_class = cls_branch;
            r.alu_op = alu_sub;
            r.branch_ne = p[13];
            v[8] = p[12];
            v[7:6] = p[6:5];
            v[5] = p[2];
            v[4:3] = p[11:10];
            v[2:1] = p[4:3];
            r.imm = {{23{v[8]}}, v[8:0]};
        end
        5'b10_000: begin   // c.slli
            r.rd = rd_f;
            r.rs1 = rd_f;
            r.op_class = cls_alu_imm;
            r.alu_op = alu_sll;
            r.imm = {26'b0, p[12], p[6:2]};
        end
        5'b10_010: begin   // c.lwsp
            r.rd = rd_f;
            r.rs1 = 5'd2;
            r.op_class = cls_load;
            v[7:6] = p[3:2];
            v[5] = p[12];
            v[4:2] = p[6:4];
            r.imm = {20'b0, v};
        end
        5'b10_110: begin   // c.swsp
            r.rs1 = 5'd2;
            r.rs2 = rs2_f;
            r.op_class = cls_store;
            v[7:6] = p[8:7];
            v[5:2] = p[12:9];
            r.imm = {20'b0, v};
        end
        5'b10_100: begin
            if (rs2_f != 5'd0) begin   // c.mv reads x0, c.add reads rd
                r.rd = rd_f;
                r.rs1 = p[12] ? rd_f : 5'd0;
                r.rs2 = rs2_f;
                r.op_class = cls_alu_reg;
            end else if (p[12] && rd_f == 5'd0) begin
                r.is_ebreak = 1'b1;
            end else begin   // c.jr / c.jalr
                r.rs1 = rd_f;
                r.rd = p[12] ? 5'd1 : 5'd0;
                r.op_class = cls_jump_reg;
            end
        end
        default: ;
    endcase

    r.wr_en = (r.op_class != cls_none) && (r.op_class != cls_store)
              && (r.op_class != cls_branch) && !r.is_ebreak && (p != 16'h0000);
    return r;
endfunction

`endif

/* sim/rvc_decoder_tb.sv */
`timescale 1ns/1ns

module rvc_decoder_tb
    import rvc_isa_pkg::*;
    import rvc_ctrl_pkg::*;
();

    localparam int N_FULL_RATE = 200;    // parcels sent with both sides always ready
    localparam int N_PARCELS   = 2000;
    localparam int WATCHDOG_NS = N_PARCELS * 4 * 4 + 4000;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    parcel_t   in_parcel;
    logic      in_ready;
    logic      out_valid;
    reg_idx_t  out_rs1;
    reg_idx_t  out_rs2;
    reg_idx_t  out_rd;
    alu_op_e   out_alu_op;
    op_class_e out_class;
    logic      out_wr_en;
    logic      out_branch_ne;
    logic      out_is_nop;
    logic      out_is_ebreak;
    logic      out_is_compressed;
    imm_t      out_imm;
    logic      out_ready;

    logic [31:0] lfsr = 32'h5894;
    dec_out_t    exp_q[$];
    int          acc_q[$];   // accept cycle, -1 when latency is not timed
    int          cycle;
    int          n_sent;
    int          n_done;
    bit          full_rate;

    `include "rvc_ref_model.svh"

    rvc_decoder_top dut_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_valid         (in_valid),
        .i_parcel        (in_parcel),
        .o_ready         (in_ready),
        .o_valid         (out_valid),
        .o_rs1           (out_rs1),
        .o_rs2           (out_rs2),
        .o_rd            (out_rd),
        .o_alu_op        (out_alu_op),
        .o_class         (out_class),
        .o_wr_en         (out_wr_en),
        .o_branch_ne     (out_branch_ne),
        .o_is_nop        (out_is_nop),
        .o_is_ebreak     (out_is_ebreak),
        .o_is_compressed (out_is_compressed),
        .o_imm           (out_imm),
        .i_out_ready     (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits[k] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return bits;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic compare_outputs(input dec_out_t e);
        check_equal("o_rs1", 32'(out_rs1), 32'(e.rs1));
        check_equal("o_rs2", 32'(out_rs2), 32'(e.rs2));
        check_equal("o_rd", 32'(out_rd), 32'(e.rd));
        check_equal("o_alu_op", 32'(out_alu_op), 32'(e.alu_op));
        check_equal("o_class", 32'(out_class), 32'(e.op_class));
        check_equal("o_wr_en", 32'(out_wr_en), 32'(e.wr_en));
        check_equal("o_branch_ne", 32'(out_branch_ne), 32'(e.branch_ne));
        check_equal("o_is_nop", 32'(out_is_nop), 32'(e.is_nop));
        check_equal("o_is_ebreak", 32'(out_is_ebreak), 32'(e.is_ebreak));
        check_equal("o_is_compressed", 32'(out_is_compressed), 32'(e.is_compressed));
        check_equal("o_imm", out_imm, e.imm);
    endtask

    // quadrant and funct3 first, so most parcels hit implemented encodings
    function automatic parcel_t next_parcel();
        parcel_t     p;
        logic [31:0] r;
        p = '0;
        r = take_bits(11);
        p[12:2] = r[10:0];
        r = take_bits(3);
        case (r[2:0])
            3'd7:       p[1:0] = 2'b11;   // full-size parcel now and then
            3'd1, 3'd4: p[1:0] = 2'b01;
            3'd2, 3'd5: p[1:0] = 2'b10;
            default:    p[1:0] = 2'b00;
        endcase
        r = take_bits(3);
        p[15:13] = r[2:0];
        if (p[1:0] != 2'b01 && take_bits(2) != 0) begin
            r = take_bits(2);
            if (p[1:0] == 2'b10) begin
                p[15:13] = {r[1:0], 1'b0};
            end else begin
                p[15:13] = {r[1] & ~r[0], r[1] | r[0], 1'b0};   // 0, 2 or 6
            end
        end
        // steer the rare splits: addi16sp, nop, mv/add against jr/jalr/ebreak
        if (p[1:0] == 2'b01 && p[15:13] == 3'd3 && take_bits(2) == 0) begin
            p[11:7] = 5'd2;
        end
        if (p[1:0] == 2'b01 && p[15:13] == 3'd0 && take_bits(3) == 0) begin
            p[11:7] = 5'd0;
        end
        if (p[1:0] == 2'b10 && p[15:13] == 3'd4) begin
            if (take_bits(2) == 0) begin
                p[6:2] = 5'd0;
            end
            if (take_bits(2) == 0) begin
                p[11:7] = 5'd0;
            end
        end
        if (take_bits(7) == 0) begin
            p = '0;
        end
        return p;
    endfunction

    // looks at the values present just before the edge
    task automatic sample_edge();
        dec_out_t e;
        int       t;
        logic     exp_ready;
        cycle++;
        exp_ready = !(exp_q.size() == 2 && !out_ready);   // both stages full
        check_equal("o_ready", 32'(in_ready), 32'(exp_ready));
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("output transfer with no parcel in flight");
            end else begin
                e = exp_q.pop_front();
                t = acc_q.pop_front();
                compare_outputs(e);
                if (t >= 0) begin
                    check_equal("latency", 32'(cycle - t), 32'd2);
                end
                n_done++;
            end
        end
        if (in_valid && in_ready) begin
            exp_q.push_back(ref_decode(in_parcel));
            acc_q.push_back(full_rate ? cycle : -1);
            n_sent++;
        end
    endtask

    task automatic drive_inputs();
        int limit;
        limit = full_rate ? N_FULL_RATE : N_PARCELS;
        if (!(in_valid && !in_ready)) begin   // a stalled parcel stays put
            if (n_sent < limit) begin
                in_valid  <= full_rate ? 1'b1 : (take_bits(2) != 0);
                in_parcel <= next_parcel();
            end else begin
                in_valid <= 1'b0;
            end
        end
        out_ready <= full_rate ? 1'b1 : (take_bits(2) != 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_parcel = '0;
        out_ready = 1'b0;
        cycle     = 0;
        n_sent    = 0;
        n_done    = 0;
        full_rate = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_equal("o_valid", 32'(out_valid), 32'd0);
        check_equal("o_ready", 32'(in_ready), 32'd1);
        drive_inputs();
        while (n_done < N_PARCELS) begin
            @(posedge clk);
            sample_edge();
            if (full_rate && n_done == N_FULL_RATE) begin
                full_rate = 1'b0;   // random valid and stalls from here on
            end
            drive_inputs();
        end
        // an empty pipe must stay quiet
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_equal("o_valid", 32'(out_valid), 32'd0);
        end
        $display("%0d parcels decoded and checked", n_done);
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog expired with %0d of %0d parcels checked",
                            n_done, N_PARCELS));
    end

endmodule

/* src/rvc_decoder_top.sv */
`timescale 1ns/1ns

module rvc_decoder_top
    import rvc_isa_pkg::*;
    import rvc_ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  parcel_t   i_parcel,
    output logic      o_ready,
    output logic      o_valid,
    output reg_idx_t  o_rs1,
    output reg_idx_t  o_rs2,
    output reg_idx_t  o_rd,
    output alu_op_e   o_alu_op,
    output op_class_e o_class,
    output logic      o_wr_en,
    output logic      o_branch_ne,
    output logic      o_is_nop,
    output logic      o_is_ebreak,
    output logic      o_is_compressed,
    output imm_t      o_imm,
    input  logic      i_out_ready
);

    logic     s1_valid;
    logic     s2_ready;
    parcel_t  s1_parcel;
    imm_fmt_e fmt;
    dec_out_t dec_d;
    dec_out_t dec_q;

    // stage 1 holds the raw parcel
    rvc_pipe_reg #(.payload_t(parcel_t)) u_stage1 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_data  (i_parcel),
        .o_valid (s1_valid),
        .i_ready (s2_ready),
        .o_data  (s1_parcel)
    );

    rvc_field_decode u_field_decode (
        .i_parcel        (s1_parcel),
        .o_rs1           (dec_d.rs1),
        .o_rs2           (dec_d.rs2),
        .o_rd            (dec_d.rd),
        .o_alu_op        (dec_d.alu_op),
        .o_class         (dec_d.op_class),
        .o_wr_en         (dec_d.wr_en),
        .o_branch_ne     (dec_d.branch_ne),
        .o_is_nop        (dec_d.is_nop),
        .o_is_ebreak     (dec_d.is_ebreak),
        .o_is_compressed (dec_d.is_compressed),
        .o_fmt           (fmt)
    );

    rvc_imm_gen u_imm_gen (
        .i_parcel (s1_parcel),
        .i_fmt    (fmt),
        .o_imm    (dec_d.imm)
    );

    // stage 2 holds the decoded fields
    rvc_pipe_reg #(.payload_t(dec_out_t)) u_stage2 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (s1_valid),
        .o_ready (s2_ready),
        .i_data  (dec_d),
        .o_valid (o_valid),
        .i_ready (i_out_ready),
        .o_data  (dec_q)
    );

    assign o_rs1           = dec_q.rs1;
    assign o_rs2           = dec_q.rs2;
    assign o_rd            = dec_q.rd;
    assign o_alu_op        = dec_q.alu_op;
    assign o_class         = dec_q.op_class;
    assign o_wr_en         = dec_q.wr_en;
    assign o_branch_ne     = dec_q.branch_ne;
    assign o_is_nop        = dec_q.is_nop;
    assign o_is_ebreak     = dec_q.is_ebreak;
    assign o_is_compressed = dec_q.is_compressed;
    assign o_imm           = dec_q.imm;

endmodule

/* src/rvc_imm_gen.sv */
`timescale 1ns/1ns

module rvc_imm_gen
    import rvc_isa_pkg::*;
    import rvc_ctrl_pkg::*;
(
    input  parcel_t  i_parcel,
    input  imm_fmt_e i_fmt,
    output imm_t     o_imm
);

    logic    s;   // sign source for the signed formats
    parcel_t p;

    assign p = i_parcel;
    assign s = i_parcel[12];

    always_comb begin
        case (i_fmt)
            fmt_ci_signed: begin
                o_imm = {{27{s}}, p[6:2]};
            end
            fmt_ci_shamt: begin
                o_imm = {26'd0, p[12], p[6:2]};
            end
            fmt_ciw_spn: begin
                // nzuimm[9:6|5:4|3|2]
                o_imm = {22'd0, p[10:7], p[12:11], p[5], p[6], 2'b00};
            end
            fmt_cl_cs_word: begin
                // uimm[6|5:3|2]
                o_imm = {25'd0, p[5], p[12:10], p[6], 2'b00};
            end
            fmt_ci_lwsp: begin
                o_imm = {24'd0, p[3:2], p[12], p[6:4], 2'b00};
            end
            fmt_css_swsp: begin
                o_imm = {24'd0, p[8:7], p[12:9], 2'b00};
            end
            fmt_ci_lui: begin
                // nzimm[17:12] into the upper field
                o_imm = {{15{s}}, p[6:2], 12'd0};
            end
            fmt_ci_sp16: begin
                // nzimm[9|8:7|6|5|4], multiple of 16
                o_imm = {{23{s}}, p[4:3], p[5], p[2], p[6], 4'd0};
            end
            fmt_cj_jump: begin
                // offset[11|10|9:8|7|6|5|4|3:1]
                o_imm = {{21{s}}, p[8], p[10:9], p[6], p[7], p[2], p[11],
                         p[5:3], 1'b0};
            end
            fmt_cb_branch: begin
                // offset[8|7:6|5|4:3|2:1]
                o_imm = {{24{s}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
            end
            default: begin
                o_imm = '0;   // no immediate, jr / jalr / register ops
            end
        endcase
    end

endmodule

/* src/rvc_field_decode.sv */
`timescale 1ns/1ns
`include "rvc_macros.svh"

module rvc_field_decode
    import rvc_isa_pkg::*;
    import rvc_ctrl_pkg::*;
(
    input  parcel_t   i_parcel,
    output reg_idx_t  o_rs1,
    output reg_idx_t  o_rs2,
    output reg_idx_t  o_rd,
    output alu_op_e   o_alu_op,
    output op_class_e o_class,
    output logic      o_wr_en,
    output logic      o_branch_ne,
    output logic      o_is_nop,
    output logic      o_is_ebreak,
    output logic      o_is_compressed,
    output imm_fmt_e  o_fmt
);

    logic [1:0] quad;
    funct3_t    funct3;
    reg_idx_t   rd_full;    // bits 11:7, CI / CR
    reg_idx_t   rs2_full;   // bits 6:2, CR / CSS
    reg_idx_t   rs1_c;      // rs1' / rd'
    reg_idx_t   rs2_c;      // rs2' / rd'

    assign quad     = i_parcel[1:0];
    assign funct3   = parcel_funct3(i_parcel);
    assign rd_full  = i_parcel[11:7];
    assign rs2_full = i_parcel[6:2];
    assign rs1_c    = creg(i_parcel[9:7]);
    assign rs2_c    = creg(i_parcel[4:2]);

    always_comb begin
        o_rs1       = `RVC_X0;
        o_rs2       = `RVC_X0;
        o_rd        = `RVC_X0;
        o_alu_op    = alu_add;
        o_class     = cls_none;
        o_fmt       = fmt_none;
        o_branch_ne = 1'b0;
        o_is_nop    = 1'b0;
        o_is_ebreak = 1'b0;

        case (quad)
            `RVC_Q0: begin
                case (funct3)
                    3'd0: begin   // addi4spn -> addi rd', x2, nzuimm
                        o_rd    = rs2_c;
                        o_rs1   = `RVC_X2;
                        o_class = cls_alu_imm;
                        o_fmt   = fmt_ciw_spn;
                    end
                    3'd2: begin   // lw
                        o_rd    = rs2_c;
                        o_rs1   = rs1_c;
                        o_class = cls_load;
                        o_fmt   = fmt_cl_cs_word;
                    end
                    3'd6: begin   // sw
                        o_rs1   = rs1_c;
                        o_rs2   = rs2_c;
                        o_class = cls_store;
                        o_fmt   = fmt_cl_cs_word;
                    end
                    default: ;
                endcase
            end
            `RVC_Q1: begin
                case (funct3)
                    3'd0: begin   // addi, nop when rd is x0
                        o_rd     = rd_full;
                        o_rs1    = rd_full;
                        o_class  = cls_alu_imm;
                        o_fmt    = fmt_ci_signed;
                        o_is_nop = (rd_full == `RVC_X0);
                    end
                    3'd1: begin   // jal -> link in x1
                        o_rd    = `RVC_X1;
                        o_class = cls_jump;
                        o_fmt   = fmt_cj_jump;
                    end
                    3'd2: begin   // li -> addi rd, x0, imm
                        o_rd    = rd_full;
                        o_class = cls_alu_imm;
                        o_fmt   = fmt_ci_signed;
                    end
                    3'd3: begin
                        if (rd_full == `RVC_X2) begin   // addi16sp
                            o_rd    = `RVC_X2;
                            o_rs1   = `RVC_X2;
                            o_class = cls_alu_imm;
                            o_fmt   = fmt_ci_sp16;
                        end else begin
                            o_rd    = rd_full;
                            o_class = cls_lui;
                            o_fmt   = fmt_ci_lui;
                        end
                    end
                    3'd4: begin
                        o_rd  = rs1_c;
                        o_rs1 = rs1_c;
                        case (i_parcel[11:10])
                            2'd0: begin
                                o_class  = cls_alu_imm;
                                o_alu_op = alu_srl;
                                o_fmt    = fmt_ci_shamt;
                            end
                            2'd1: begin
                                o_class  = cls_alu_imm;
                                o_alu_op = alu_sra;
                                o_fmt    = fmt_ci_shamt;
                            end
                            2'd2: begin
                                o_class  = cls_alu_imm;
                                o_alu_op = alu_and;
                                o_fmt    = fmt_ci_signed;
                            end
                            default: begin
                                if (!i_parcel[12]) begin   // sub / xor / or / and
                                    o_rs2   = rs2_c;
                                    o_class = cls_alu_reg;
                                    case (i_parcel[6:5])
                                        2'd0:    o_alu_op = alu_sub;
                                        2'd1:    o_alu_op = alu_xor;
                                        2'd2:    o_alu_op = alu_or;
                                        default: o_alu_op = alu_and;
                                    endcase
                                end else begin
                                    o_rd  = `RVC_X0;   // rv64 only, left undecoded
                                    o_rs1 = `RVC_X0;
                                end
                            end
                        endcase
                    end
                    3'd5: begin   // j -> jal x0
                        o_class = cls_jump;
                        o_fmt   = fmt_cj_jump;
                    end
                    default: begin   // beqz / bnez compare against x0
                        o_rs1       = rs1_c;
                        o_class     = cls_branch;
                        o_alu_op    = alu_sub;
                        o_fmt       = fmt_cb_branch;
                        o_branch_ne = funct3[0];
                    end
                endcase
            end
            `RVC_Q2: begin
                case (funct3)
                    3'd0: begin   // slli
                        o_rd     = rd_full;
                        o_rs1    = rd_full;
                        o_class  = cls_alu_imm;
                        o_alu_op = alu_sll;
                        o_fmt    = fmt_ci_shamt;
                    end
                    3'd2: begin   // lwsp
                        o_rd    = rd_full;
                        o_rs1   = `RVC_X2;
                        o_class = cls_load;
                        o_fmt   = fmt_ci_lwsp;
                    end
                    3'd6: begin   // swsp
                        o_rs1   = `RVC_X2;
                        o_rs2   = rs2_full;
                        o_class = cls_store;
                        o_fmt   = fmt_css_swsp;
                    end
                    3'd4: begin
                        if (rs2_full != `RVC_X0) begin
                            // add keeps rd as a source, mv reads x0
                            o_rd    = rd_full;
                            o_rs1   = i_parcel[12] ? rd_full : `RVC_X0;
                            o_rs2   = rs2_full;
                            o_class = cls_alu_reg;
                        end else if (i_parcel[12] && rd_full == `RVC_X0) begin
                            o_is_ebreak = 1'b1;
                        end else begin   // jr / jalr
                            o_rs1   = rd_full;
                            o_rd    = i_parcel[12] ? `RVC_X1 : `RVC_X0;
                            o_class = cls_jump_reg;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;   // full-size instruction
        endcase

        o_wr_en = !(o_class inside {cls_none, cls_store, cls_branch})
                  && !o_is_ebreak && (i_parcel != '0);

        if (!$isunknown(i_parcel)) begin
            // stores and branches name no destination
            a_no_dest: assert (!(o_class inside {cls_store, cls_branch})
                || o_rd == `RVC_X0);
            // memory ops always carry a word offset
            a_mem_fmt: assert (!(o_class inside {cls_load, cls_store})
                || o_fmt inside {fmt_cl_cs_word, fmt_ci_lwsp, fmt_css_swsp});
        end
    end

    assign o_is_compressed = (quad != `RVC_Q_FULL);

endmodule

/* src/rvc_pipe_reg.sv */
`timescale 1ns/1ns

module rvc_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic load;

    // accept when empty or when the held item leaves this cycle
    assign o_ready = !o_valid || i_ready;
    assign load    = i_valid && o_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            o_data <= i_data;   // payload only moves on a transfer
        end
    end

    // a stalled item must not change or vanish
    a_hold_on_stall: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_data)
    );

    // valid only rises after something was accepted
    a_no_phantom: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_valid) |-> $past(i_valid)
    );

endmodule

/* src/rvc_ctrl_pkg.sv */
`include "rvc_macros.svh"

package rvc_ctrl_pkg;

    import rvc_isa_pkg::*;

    // alu operations, codes 6 and 7 left free
    typedef enum logic [3:0] {
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_sll = 4'd8,
        alu_srl = 4'd9,
        alu_sra = 4'd10
    } alu_op_e;

    // nine classes, so four bits
    typedef enum logic [3:0] {
        cls_none,
        cls_alu_imm,
        cls_alu_reg,
        cls_lui,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,       // jal / j
        cls_jump_reg    // jalr / jr
    } op_class_e;

    typedef logic [`RVC_XLEN-1:0] imm_t;

    // payload of the output stage
    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        alu_op_e   alu_op;
        op_class_e op_class;
        logic      wr_en;
        logic      branch_ne;
        logic      is_nop;
        logic      is_ebreak;
        logic      is_compressed;
        imm_t      imm;
    } dec_out_t;

endpackage

/* src/rvc_isa_pkg.sv */
`include "rvc_macros.svh"

package rvc_isa_pkg;

    // raw fetch parcel
    typedef logic [`RVC_PARCEL_W-1:0] parcel_t;

    // architectural register index
    typedef logic [`RVC_REG_W-1:0] reg_idx_t;

    // funct3 sits in parcel bits 15:13 for every quadrant
    typedef logic [2:0] funct3_t;

    // immediate layouts of the compressed formats
    typedef enum logic [3:0] {
        fmt_none       = 4'd0,
        fmt_ci_signed  = 4'd1,   // addi, li, andi
        fmt_ci_shamt   = 4'd2,   // slli, srli, srai
        fmt_ciw_spn    = 4'd3,   // addi4spn
        fmt_cl_cs_word = 4'd4,   // lw, sw
        fmt_ci_lwsp    = 4'd5,
        fmt_css_swsp   = 4'd6,
        fmt_ci_lui     = 4'd7,
        fmt_ci_sp16    = 4'd8,   // addi16sp
        fmt_cj_jump    = 4'd9,
        fmt_cb_branch  = 4'd10
    } imm_fmt_e;

    // 3-bit rd'/rs1'/rs2' field to full index
    function automatic reg_idx_t creg(input logic [2:0] i_field);
        return {`RVC_CREG_BASE, i_field};
    endfunction

    // funct3 of a parcel
    function automatic funct3_t parcel_funct3(input parcel_t i_p);
        return i_p[15:13];
    endfunction

endpackage

/* src/rvc_macros.svh */
`ifndef RVC_MACROS_SVH
`define RVC_MACROS_SVH

// parcel and datapath widths
`define RVC_PARCEL_W 16
`define RVC_REG_W    5
`define RVC_XLEN     32

// quadrant codes in parcel bits 1:0
`define RVC_Q0     2'b00
`define RVC_Q1     2'b01
`define RVC_Q2     2'b10
`define RVC_Q_FULL 2'b11   // not compressed, 32-bit instruction

// compressed register fields map onto x8..x15
`define RVC_CREG_BASE 2'b01

// registers implied by the expansion
`define RVC_X0 5'd0
`define RVC_X1 5'd1
`define RVC_X2 5'd2

`endif
